// File: vlog.f
+incdir+include
source/stats_pkg.sv
source/stat_stream_if.sv
source/stat_event_collector.sv
source/stat_stream_arbiter.sv
source/stats_counter.sv
source/stats_top.sv
tests/stats_tb.sv

// File: Bender.yml
package:
  name: stats_counter_subsystem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/stats_pkg.sv
      - source/stat_stream_if.sv
      - source/stat_event_collector.sv
      - source/stat_stream_arbiter.sv
      - source/stats_counter.sv
      - source/stats_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/stats_tb.sv

// File: tests/stats_tb.sv
// testbench for stats_top with clock, reset, stimulus, reference model, AXI-Lite access and checks
`timescale 1ns/100ps
`include "stats_settings.svh"

module stats_tb
    import stats_pkg::*;
();

    localparam int ADDR_W = `AXIL_ADDR_W;
    localparam int DATA_W = `AXIL_DATA_W;
    localparam int SWEEP = 2**`STAT_ID_W;
    localparam int QUIET_CYCLES = 20;
    localparam int N_EVENTS = 50 + 400 * `STAT_SOURCES;
    localparam int N_READS = 100;
    localparam int WATCHDOG_CYCLES = N_EVENTS + 64 * N_READS + 200;
    localparam int EVENT_RNG = 0;
    localparam int READ_RNG = 1;

    logic clk;
    logic rst;
    logic [`STAT_SOURCES-1:0] event_valid;
    stat_event_t [`STAT_SOURCES-1:0] event_inc;
    logic [`STAT_SOURCES-1:0] event_ready;
    logic [ADDR_W-1:0] araddr;
    logic arvalid;
    logic arready;
    logic [DATA_W-1:0] rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;
    logic [ADDR_W-1:0] awaddr;
    logic awvalid;
    logic awready;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W/8-1:0] wstrb;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;

    stat_count_t expected [`STAT_SOURCES];
    // separate streams for event and read stimulus
    logic [15:0] lfsr_state [2];
    int since_reset;
    int value_errors;
    int protocol_errors;
    logic stim_done;

    stats_top UUT (
        .clk (clk), .rst (rst),
        .event_valid (event_valid), .event_inc (event_inc), .event_ready (event_ready),
        .araddr (araddr), .arvalid (arvalid), .arready (arready), .rdata (rdata),
        .rresp (rresp), .rvalid (rvalid), .rready (rready),
        .awaddr (awaddr), .awvalid (awvalid), .awready (awready), .wdata (wdata),
        .wstrb (wstrb), .wvalid (wvalid), .wready (wready), .bresp (bresp),
        .bvalid (bvalid), .bready (bready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] random_bits(input int stream, input int n);
        logic [31:0] value;
        logic out_bit;
        value = '0;
        for (int b = 0; b < n; b++) begin
            out_bit = lfsr_state[stream][0];
            lfsr_state[stream] = lfsr_state[stream] >> 1;
            if (out_bit) begin
                lfsr_state[stream] = lfsr_state[stream] ^ 16'hB400;
            end
            value = {value[30:0], out_bit};
        end
        return value;
    endfunction

    // reference totals count only accepted events
    always @(posedge clk) begin
        for (int i = 0; i < `STAT_SOURCES; i++) begin
            if (rst) begin
                expected[i] <= '0;
            end else if (event_valid[i] && event_ready[i]) begin
                expected[i] <= expected[i] + stat_count_t'(event_inc[i]);
            end
        end
        since_reset <= rst ? 0 : since_reset + 1;
    end

    after_reset: assert property (@(posedge clk) $fell(rst) |->
        event_ready == '1 && !arready && !awready && !wready && !rvalid && !bvalid)
        else begin
            protocol_errors++;
            $display("outputs not in their idle state after reset");
        end

    sweep_busy: assert property (@(posedge clk) disable iff (rst)
        since_reset <= SWEEP |-> !arready)
        else begin
            protocol_errors++;
            $display("read accepted during the counter clear sweep");
        end

    rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else begin
            protocol_errors++;
            $display("rvalid dropped or rdata changed while rready was low");
        end

    rresp_okay: assert property (@(posedge clk) disable iff (rst)
        rvalid |-> rresp == 2'b00)
        else begin
            protocol_errors++;
            $display("read response was not OKAY");
        end

    bresp_okay: assert property (@(posedge clk) disable iff (rst)
        bvalid |-> bresp == 2'b00)
        else begin
            protocol_errors++;
            $display("write response was not OKAY");
        end

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
        assert (got == exp)
            else begin
                value_errors++;
                $display("FAILED %s expected %h actual %h", name, exp, got);
            end
    endtask

    // called at an edge and returns at the data handshake edge
    task automatic read_word(input int id, input int word, output logic [DATA_W-1:0] data);
        int delay;
        araddr <= ADDR_W'(id * 8 + word * 4);
        arvalid <= 1'b1;
        do @(posedge clk); while (!arready);
        arvalid <= 1'b0;
        while (!rvalid) @(posedge clk);
        delay = random_bits(READ_RNG, 2);
        repeat (delay) @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        data = rdata;
        rready <= 1'b0;
    endtask

    task automatic check_all(input string name);
        logic [DATA_W-1:0] got;
        for (int id = 0; id < `STAT_SOURCES; id++) begin
            for (int w = 0; w < 2; w++) begin
                read_word(id, w, got);
                check_value(name, 64'(expected[id][w*32 +: 32]), 64'(got));
            end
        end
    endtask

    task automatic send_event(input int src, input stat_event_t value);
        event_valid[src] <= 1'b1;
        event_inc[src] <= value;
        do @(posedge clk); while (!event_ready[src]);
        event_valid[src] <= 1'b0;
    endtask

    task automatic drive_all_sources(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(posedge clk);
            for (int i = 0; i < `STAT_SOURCES; i++) begin
                if (!event_valid[i] || event_ready[i]) begin
                    event_valid[i] <= (random_bits(EVENT_RNG, 1) != 0);
                    event_inc[i] <= stat_event_t'(random_bits(EVENT_RNG, 8));
                end
            end
        end
    endtask

    // held events finish before the sources go idle
    task automatic drain_events();
        logic busy;
        forever begin
            @(posedge clk);
            busy = 1'b0;
            for (int i = 0; i < `STAT_SOURCES; i++) begin
                if (event_valid[i] && !event_ready[i]) begin
                    busy = 1'b1;
                end else begin
                    event_valid[i] <= 1'b0;
                end
            end
            if (!busy) begin
                break;
            end
        end
    endtask

    task automatic wait_quiet();
        int idle;
        idle = 0;
        while (idle < QUIET_CYCLES) begin
            @(posedge clk);
            if (event_valid == '0 && UUT.pending_valid == '0 && !UUT.stat.tvalid) begin
                idle++;
            end else begin
                idle = 0;
            end
        end
    endtask

    task automatic write_discard(input int id);
        logic seen_aw;
        logic seen_b;
        seen_aw = 1'b0;
        seen_b = 1'b0;
        awaddr <= ADDR_W'(id * 8);
        wdata <= '1;
        wstrb <= '1;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        while (!(seen_aw && seen_b)) begin
            @(posedge clk);
            assert (!bvalid || seen_aw)
                else begin
                    protocol_errors++;
                    $display("bvalid came before the write address and data were taken");
                end
            if (!seen_aw && awready) begin
                assert (wready)
                    else begin
                        protocol_errors++;
                        $display("wready did not pulse together with awready");
                    end
                seen_aw = 1'b1;
                awvalid <= 1'b0;
                wvalid <= 1'b0;
            end
            if (bvalid) begin
                seen_b = 1'b1;
            end
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d clock periods", WATCHDOG_CYCLES);
        $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
        $display("sim failed");
        $finish;
    end

    initial begin
        logic [DATA_W-1:0] got;
        lfsr_state[EVENT_RNG] = 16'd64;
        lfsr_state[READ_RNG] = 16'd64;
        value_errors = 0;
        protocol_errors = 0;
        stim_done = 1'b0;
        {event_valid, event_inc, araddr, arvalid, rready} = '0;
        {awaddr, awvalid, wdata, wstrb, wvalid} = '0;
        bready = 1'b1;
        rst = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // first read is issued while the sweep runs
        check_all("post_reset_zero");

        for (int n = 0; n < 50; n++) begin
            send_event(1, stat_event_t'(random_bits(EVENT_RNG, 8)));
            repeat (random_bits(EVENT_RNG, 2)) @(posedge clk);
        end
        wait_quiet();
        check_all("single_source_sum");

        fork
            begin
                drive_all_sources(400);
                drain_events();
                stim_done <= 1'b1;
            end
            begin : interleaved_reads
                int rid;
                while (!stim_done) begin
                    rid = random_bits(READ_RNG, 2);
                    read_word(rid, 0, got);
                    assert (got <= expected[rid][31:0])
                        else begin
                            value_errors++;
                            $display("FAILED interleaved_read expected at most %h actual %h",
                                     expected[rid][31:0], got);
                        end
                end
            end
        join
        wait_quiet();
        check_all("all_sources_backpressure");

        write_discard(2);
        read_word(2, 0, got);
        check_value("write_discard", 64'(expected[2][31:0]), 64'(got));

        $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: source/stats_top.sv
// stats_top: event collector, arbiter and counter block joined with plain ports
`timescale 1ns/100ps
`include "stats_settings.svh"

module stats_top
    import stats_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst,

    input  logic [`STAT_SOURCES-1:0]          event_valid,
    input  stat_event_t [`STAT_SOURCES-1:0]   event_inc,
    output logic [`STAT_SOURCES-1:0]          event_ready,

    input  logic [`AXIL_ADDR_W-1:0]           araddr,
    input  logic                              arvalid,
    output logic                              arready,
    output logic [`AXIL_DATA_W-1:0]           rdata,
    output logic [1:0]                        rresp,
    output logic                              rvalid,
    input  logic                              rready,

    // write address and data are not decoded
    input  logic [`AXIL_ADDR_W-1:0]           awaddr,
    input  logic                              awvalid,
    output logic                              awready,
    input  logic [`AXIL_DATA_W-1:0]           wdata,
    input  logic [`AXIL_DATA_W/8-1:0]         wstrb,
    input  logic                              wvalid,
    output logic                              wready,
    output logic [1:0]                        bresp,
    output logic                              bvalid,
    input  logic                              bready
);

    logic [`STAT_SOURCES-1:0] pending_valid;
    stat_inc_t [`STAT_SOURCES-1:0] pending;
    logic [`STAT_SOURCES-1:0] take;

    stat_stream_if stat ();

    stat_event_collector u_collector (
        .clk           (clk),
        .rst           (rst),
        .event_valid   (event_valid),
        .event_inc     (event_inc),
        .event_ready   (event_ready),
        .pending_valid (pending_valid),
        .pending       (pending),
        .take          (take)
    );

    stat_stream_arbiter u_arbiter (
        .clk           (clk),
        .rst           (rst),
        .pending_valid (pending_valid),
        .pending       (pending),
        .take          (take),
        .stat          (stat.src)
    );

    stats_counter u_counter (
        .clk     (clk),
        .rst     (rst),
        .stat    (stat.snk),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .awvalid (awvalid),
        .awready (awready),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready)
    );

endmodule

// File: source/stats_counter.sv
// RAM counter block with init sweep, accumulate pipeline and AXI-Lite port
`timescale 1ns/100ps
`include "stats_settings.svh"

module stats_counter
    import stats_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    stat_stream_if.snk                stat,

    input  logic [`AXIL_ADDR_W-1:0]   araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [`AXIL_DATA_W-1:0]   rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,

    input  logic                      awvalid,
    output logic                      awready,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready
);

    localparam int PIPE = `STAT_PIPELINE;
    localparam int DATA_W = `AXIL_DATA_W;
    localparam int ID_SHIFT = $clog2(`STAT_COUNT_W / 8);
    localparam int WORD_SHIFT = $clog2(DATA_W / 8);
    localparam int WORD_W = $clog2(`STAT_COUNT_W / DATA_W);
    localparam logic [1:0] RESP_OKAY = 2'b00;

    logic init_reg;
    stat_id_t init_ptr_reg;

    // per-stage operation tags
    logic [PIPE-1:0] op_rd_reg;
    logic [PIPE-1:0] op_acc_reg;

    // per-stage payload
    stat_id_t id_pipe_reg [PIPE];
    logic [WORD_W-1:0] word_pipe_reg [PIPE];
    stat_inc_t inc_pipe_reg [PIPE];

    logic tready_reg;
    logic arready_reg;
    logic rvalid_reg;
    logic [DATA_W-1:0] rdata_reg;
    logic awready_reg;
    logic wready_reg;
    logic bvalid_reg;

    stat_count_t mem [2**`STAT_ID_W];
    stat_count_t mem_rd_data_reg;
    stat_count_t mem_rd_pipe_reg [1:PIPE-1];
    stat_id_t mem_wr_addr;
    stat_count_t mem_wr_data;
    logic mem_wr_en;

    stat_id_t ar_id;
    logic [WORD_W-1:0] ar_word;
    stat_id_t start_id;
    logic hazard;
    logic rd_start;
    logic acc_start;
    logic wr_start;

    assign stat.tready = tready_reg;

    assign arready = arready_reg;
    assign rdata = rdata_reg;
    assign rresp = RESP_OKAY;
    assign rvalid = rvalid_reg;

    assign awready = awready_reg;
    assign wready = wready_reg;
    assign bresp = RESP_OKAY;
    assign bvalid = bvalid_reg;

    // id x 8 + word x 4
    assign ar_id = stat_id_t'(araddr >> ID_SHIFT);
    assign ar_word = WORD_W'(araddr >> WORD_SHIFT);

    // same id anywhere in flight blocks the increment
    always_comb begin
        hazard = 1'b0;
        for (int j = 0; j < PIPE; j++) begin
            if ((op_rd_reg[j] || op_acc_reg[j]) && id_pipe_reg[j] == stat.tid) begin
                hazard = 1'b1;
            end
        end
    end

    // reads win over increments and run one at a time
    assign rd_start = !init_reg && arvalid && (!rvalid_reg || rready) && op_rd_reg == '0;
    assign acc_start = !init_reg && !rd_start && stat.tvalid && !tready_reg && !hazard;
    assign start_id = rd_start ? ar_id : stat.tid;

    // writes are acknowledged and their data dropped
    assign wr_start = !init_reg && awvalid && wvalid && (!bvalid_reg || bready)
        && !awready_reg && !wready_reg;

    always_comb begin
        if (init_reg) begin
            mem_wr_en = 1'b1;
            mem_wr_addr = init_ptr_reg;
            mem_wr_data = '0;
        end else begin
            mem_wr_en = op_acc_reg[PIPE-1];
            mem_wr_addr = id_pipe_reg[PIPE-1];
            mem_wr_data = mem_rd_pipe_reg[PIPE-1] + stat_count_t'(inc_pipe_reg[PIPE-1]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            init_reg <= 1'b1;
            init_ptr_reg <= '0;
            op_rd_reg <= '0;
            op_acc_reg <= '0;
            tready_reg <= 1'b0;
            arready_reg <= 1'b0;
            rvalid_reg <= 1'b0;
            awready_reg <= 1'b0;
            wready_reg <= 1'b0;
            bvalid_reg <= 1'b0;
        end else begin
            if (init_reg) begin
                init_ptr_reg <= init_ptr_reg + 1'b1;
                if (&init_ptr_reg) begin
                    init_reg <= 1'b0;
                end
            end
            op_rd_reg <= {op_rd_reg[PIPE-2:0], rd_start};
            op_acc_reg <= {op_acc_reg[PIPE-2:0], acc_start};
            tready_reg <= acc_start;
            arready_reg <= rd_start;
            rvalid_reg <= op_rd_reg[PIPE-1] || (rvalid_reg && !rready);
            awready_reg <= wr_start;
            wready_reg <= wr_start;
            // response once address and data have been taken
            bvalid_reg <= awready_reg || (bvalid_reg && !bready);
        end
    end

    // stage payload moves every cycle and the tags say what is live
    always_ff @(posedge clk) begin
        id_pipe_reg[0] <= start_id;
        word_pipe_reg[0] <= ar_word;
        inc_pipe_reg[0] <= stat.tdata;
        for (int j = 1; j < PIPE; j++) begin
            id_pipe_reg[j] <= id_pipe_reg[j-1];
            word_pipe_reg[j] <= word_pipe_reg[j-1];
            inc_pipe_reg[j] <= inc_pipe_reg[j-1];
        end

        if (op_rd_reg[PIPE-1]) begin
            rdata_reg <= DATA_W'(mem_rd_pipe_reg[PIPE-1] >> (word_pipe_reg[PIPE-1] * DATA_W));
        end
    end

    // counter RAM
    always_ff @(posedge clk) begin
        if (mem_wr_en) begin
            mem[mem_wr_addr] <= mem_wr_data;
        end
        mem_rd_data_reg <= mem[start_id];
        mem_rd_pipe_reg[1] <= mem_rd_data_reg;
        for (int j = 2; j < PIPE; j++) begin
            mem_rd_pipe_reg[j] <= mem_rd_pipe_reg[j-1];
        end
    end

endmodule

// File: source/stat_stream_arbiter.sv
// stat_stream_arbiter: round-robin pick of pending sums into the increment stream
`timescale 1ns/100ps
`include "stats_settings.svh"

module stat_stream_arbiter
    import stats_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst,

    input  logic [`STAT_SOURCES-1:0]          pending_valid,
    input  stat_inc_t [`STAT_SOURCES-1:0]     pending,
    output logic [`STAT_SOURCES-1:0]          take,

    stat_stream_if.src                        stat
);

    stat_id_t last_reg;
    stat_id_t cand;
    stat_id_t pick;
    logic found;
    logic load;

    logic out_valid_reg;
    stat_inc_t out_data_reg;
    stat_id_t out_id_reg;

    assign stat.tvalid = out_valid_reg;
    assign stat.tdata = out_data_reg;
    assign stat.tid = out_id_reg;

    // register empty or draining this cycle
    assign load = !out_valid_reg || stat.tready;

    // search starts just after the last winner
    always_comb begin
        found = 1'b0;
        pick = last_reg;
        cand = last_reg;
        for (int k = 1; k <= `STAT_SOURCES; k++) begin
            cand = stat_id_t'(last_reg + k);
            if (!found && pending_valid[cand]) begin
                found = 1'b1;
                pick = cand;
            end
        end

        take = '0;
        if (load && found) begin
            take[pick] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_reg <= 1'b0;
            last_reg <= '0;
        end else if (load) begin
            out_valid_reg <= found;
            if (found) begin
                last_reg <= pick;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load && found) begin
            out_data_reg <= pending[pick];
            out_id_reg <= pick;
        end
    end

endmodule

// File: source/stat_event_collector.sv
// stat_event_collector: per-source pending sums with event back-pressure
`timescale 1ns/100ps
`include "stats_settings.svh"

module stat_event_collector
    import stats_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst,

    input  logic [`STAT_SOURCES-1:0]          event_valid,
    input  stat_event_t [`STAT_SOURCES-1:0]   event_inc,
    output logic [`STAT_SOURCES-1:0]          event_ready,

    output logic [`STAT_SOURCES-1:0]          pending_valid,
    output stat_inc_t [`STAT_SOURCES-1:0]     pending,
    input  logic [`STAT_SOURCES-1:0]          take
);

    logic [`STAT_SOURCES-1:0] accept;

    // a sum with its top bit clear still has room for one more event
    always_comb begin
        for (int i = 0; i < `STAT_SOURCES; i++) begin
            event_ready[i] = !pending[i][`STAT_INC_W-1];
            accept[i] = event_valid[i] && event_ready[i];
            pending_valid[i] = |pending[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            for (int i = 0; i < `STAT_SOURCES; i++) begin
                if (take[i]) begin
                    // old sum handed over, keep only the new event
                    if (accept[i]) begin
                        pending[i] <= stat_inc_t'(event_inc[i]);
                    end else begin
                        pending[i] <= '0;
                    end
                end else if (accept[i]) begin
                    pending[i] <= pending[i] + stat_inc_t'(event_inc[i]);
                end
            end
        end
    end

endmodule

// File: source/stat_stream_if.sv
// interface for the tagged increment stream with source and sink modports
`timescale 1ns/100ps

interface stat_stream_if
    import stats_pkg::*;
();

    logic tvalid;
    logic tready;
    stat_inc_t tdata;
    stat_id_t tid;

    // arbiter side
    modport src (
        output tvalid,
        output tdata,
        output tid,
        input  tready
    );

    // counter side
    modport snk (
        input  tvalid,
        input  tdata,
        input  tid,
        output tready
    );

endinterface

// File: source/stats_pkg.sv
// id, increment, pending-sum and counter types for the statistics path
`include "stats_settings.svh"

package stats_pkg;

    // source number, also the counter index
    typedef logic [`STAT_ID_W-1:0] stat_id_t;

    // one event from a source
    typedef logic [`STAT_EVENT_W-1:0] stat_event_t;

    // pending sum and stream increment
    typedef logic [`STAT_INC_W-1:0] stat_inc_t;

    // counter value in RAM
    typedef logic [`STAT_COUNT_W-1:0] stat_count_t;

endpackage

// File: include/stats_settings.svh
// sizes and pipeline depth of the statistics counter subsystem
`ifndef STATS_SETTINGS_SVH
`define STATS_SETTINGS_SVH

// event sources, one counter each
`define STAT_SOURCES 4
`define STAT_ID_W 2

// increment widths
`define STAT_EVENT_W 8
`define STAT_INC_W 16

// counter held as two bus words
`define STAT_COUNT_W 64

`define AXIL_ADDR_W 8
`define AXIL_DATA_W 32

// read-modify-write depth, at least 2
`define STAT_PIPELINE 2

`endif
